/* dv/lsu_checker.sv */
`timescale 1ns/10ps

module lsu_checker (
	input logic clock,
	input logic reset,
	input logic aw_valid,
	input logic aw_ready,
	input lsu_pkg::addr_t aw_addr,
	input logic w_valid,
	input logic w_ready,
	input lsu_pkg::beat_t w_data,
	input lsu_pkg::strb_t w_strb,
	input logic ar_valid,
	input logic ar_ready,
	input lsu_pkg::addr_t ar_addr,
	input logic done
);
	int unsigned error_count = 0;

	// valid and payload hold until the transfer
	aw_hold: assert property (@(posedge clock) disable iff (reset)
		aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr))
	else begin
		error_count = error_count + 1;
		$error("aw_valid dropped or aw_addr changed before aw_ready");
	end

	w_hold: assert property (@(posedge clock) disable iff (reset)
		w_valid && !w_ready |=> w_valid && $stable(w_data) && $stable(w_strb))
	else begin
		error_count = error_count + 1;
		$error("w_valid dropped or write payload changed before w_ready");
	end

	ar_hold: assert property (@(posedge clock) disable iff (reset)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
	else begin
		error_count = error_count + 1;
		$error("ar_valid dropped or ar_addr changed before ar_ready");
	end

	strb_nonzero: assert property (@(posedge clock) disable iff (reset)
		w_valid |-> w_strb != '0)
	else begin
		error_count = error_count + 1;
		$error("w_strb is zero while w_valid is high");
	end

	// done is a single-cycle pulse
	done_pulse: assert property (@(posedge clock) disable iff (reset)
		done |=> !done)
	else begin
		error_count = error_count + 1;
		$error("done stayed high for two cycles");
	end

endmodule

bind lsu_bus_master lsu_checker u_checker (.*);

/* dv/lsu_tb_tasks.svh */
// one clock, then settle past the edge
task automatic step();
	@(posedge clock);
	#1;
endtask

function automatic int unsigned lcg_next(input int unsigned s);
	return s * 32'd1103515245 + 32'd12345;
endfunction

// memory ready/valid delay, 0 to 3 cycles
function automatic int unsigned next_delay();
	delay_state = lcg_next(delay_state);
	return (delay_state >> 16) % 4;
endfunction

// fold the upper half down so every bit of the result varies
function automatic int unsigned next_stim();
	stim_state = lcg_next(stim_state);
	return stim_state ^ (stim_state >> 16);
endfunction

function automatic byte_t fill_byte(input int a);
	return byte_t'((a * 29) ^ (a >> 3) ^ 8'h6b);
endfunction

function automatic int access_bytes(input size_t size);
	case (size)
		SIZE_BYTE: return 1;
		SIZE_HALF: return 2;
		default: return 4;
	endcase
endfunction

function automatic mem_req_t make_req(input logic is_store, input logic is_unsigned,
		input size_t size, input addr_t addr, input word_t wdata);
	mem_req_t r;
	r.is_store = is_store;
	r.is_unsigned = is_unsigned;
	r.size = size;
	r.addr = addr;
	r.wdata = wdata;
	return r;
endfunction

// little endian store into the byte model
task automatic model_store(input mem_req_t r);
	for (int i = 0; i < access_bytes(r.size); i++) begin
		model[r.addr[7:0] + i] = r.wdata[8*i +: 8];
	end
endtask

function automatic word_t model_load(input mem_req_t r);
	word_t value;
	int n;
	n = access_bytes(r.size);
	value = '0;
	for (int i = 0; i < n; i++) begin
		value[8*i +: 8] = model[r.addr[7:0] + i];
	end
	// sign fill above the top loaded byte
	if (!r.is_unsigned && value[8*n-1]) begin
		for (int i = 8 * n; i < 32; i++) begin
			value[i] = 1'b1;
		end
	end
	return value;
endfunction

// issue a request, then wait for its done while req_ready stays low
task automatic run_access(input mem_req_t r, output word_t result);
	req = r;
	req_valid = 1'b1;
	while (req_ready !== 1'b1) step();
	step();
	req_valid = 1'b0;
	while (done !== 1'b1) begin
		check_value("req_ready", 0, req_ready);
		step();
	end
	// free again in the done cycle
	check_value("req_ready", 1, req_ready);
	result = load_data;
endtask

task automatic access_and_check(input mem_req_t r);
	word_t result;
	run_access(r, result);
	if (r.is_store) begin
		model_store(r);
		check_memory();
	end else begin
		check_value("load_data", model_load(r), result);
	end
endtask

/* dv/lsu_tb.sv */
`timescale 1ns/10ps

module lsu_tb;
	import lsu_pkg::*;

	localparam int CLOCK_PERIOD = 40;
	localparam int NUM_REQS = 85;
	localparam int MEM_BYTES = 256;

	logic clock;
	logic reset;
	logic req_valid;
	mem_req_t req;
	logic req_ready;
	logic done;
	word_t load_data;
	logic aw_valid;
	logic aw_ready;
	addr_t aw_addr;
	logic w_valid;
	logic w_ready;
	beat_t w_data;
	strb_t w_strb;
	logic b_valid;
	logic b_ready;
	logic ar_valid;
	logic ar_ready;
	addr_t ar_addr;
	logic r_valid;
	logic r_ready;
	beat_t r_data;

	byte_t mem [MEM_BYTES];
	byte_t model [MEM_BYTES];
	addr_t wr_addrs [$];
	addr_t rd_addrs [$];
	int unsigned delay_state = 38209;
	int unsigned stim_state = 38209;

	lsu_top uut (.*);

	`include "lsu_tb_tasks.svh"

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (actual !== expected) begin
			$display("Fail at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
			$display("=== FAIL ===");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	task automatic check_memory();
		for (int i = 0; i < MEM_BYTES; i++) begin
			check_value($sformatf("mem[%0d]", i), model[i], mem[i]);
		end
	endtask

	// run one access, then check its beat count and beat addresses
	task automatic access_counting_beats(input mem_req_t r, input addr_t base,
			input int beats);
		wr_addrs.delete();
		rd_addrs.delete();
		access_and_check(r);
		if (r.is_store) begin
			check_value("write beats", beats, wr_addrs.size());
			check_value("aw_addr first", base, wr_addrs[0]);
			if (beats > 1) begin
				check_value("aw_addr second", base + 8, wr_addrs[1]);
			end
		end else begin
			check_value("read beats", beats, rd_addrs.size());
			check_value("ar_addr first", base, rd_addrs[0]);
			if (beats > 1) begin
				check_value("ar_addr second", base + 8, rd_addrs[1]);
			end
		end
	endtask

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	// write side of the memory: address, data, then response
	initial begin : write_slave
		addr_t addr;
		beat_t data;
		strb_t strb;
		aw_ready = 1'b0;
		w_ready = 1'b0;
		b_valid = 1'b0;
		for (int i = 0; i < MEM_BYTES; i++) begin
			mem[i] = fill_byte(i);
		end
		forever begin
			while (aw_valid !== 1'b1) step();
			repeat (next_delay()) step();
			aw_ready = 1'b1;
			addr = aw_addr;
			step();
			aw_ready = 1'b0;
			wr_addrs.push_back(addr);
			while (w_valid !== 1'b1) step();
			repeat (next_delay()) step();
			w_ready = 1'b1;
			data = w_data;
			strb = w_strb;
			step();
			w_ready = 1'b0;
			for (int i = 0; i < BEAT_BYTES; i++) begin
				if (strb[i]) mem[addr[7:0] + i] = data[8*i +: 8];
			end
			repeat (next_delay()) step();
			b_valid = 1'b1;
			while (b_ready !== 1'b1) step();
			step();
			b_valid = 1'b0;
		end
	end

	initial begin : read_slave
		addr_t addr;
		ar_ready = 1'b0;
		r_valid = 1'b0;
		r_data = '0;
		forever begin
			while (ar_valid !== 1'b1) step();
			repeat (next_delay()) step();
			ar_ready = 1'b1;
			addr = ar_addr;
			step();
			ar_ready = 1'b0;
			rd_addrs.push_back(addr);
			repeat (next_delay()) step();
			for (int i = 0; i < BEAT_BYTES; i++) begin
				r_data[8*i +: 8] = mem[addr[7:0] + i];
			end
			r_valid = 1'b1;
			while (r_ready !== 1'b1) step();
			step();
			r_valid = 1'b0;
			r_data = '0;
		end
	end

	// each request gets 40 cycles, plus room for reset
	initial begin : watchdog
		#(CLOCK_PERIOD * (NUM_REQS * 40 + 200));
		$display("Timeout: the tests did not finish in the expected time");
		$display("=== FAIL ===");
		$fatal(1, "watchdog expired");
	end

	initial begin : assertion_watch
		wait (uut.u_master.u_checker.error_count != 0);
		$display("A bus protocol assertion failed in the bus master");
		$display("=== FAIL ===");
		$fatal(1, "protocol assertion failed");
	end

	task automatic test_reset_state();
		check_value("aw_valid", 0, aw_valid);
		check_value("w_valid", 0, w_valid);
		check_value("b_ready", 0, b_ready);
		check_value("ar_valid", 0, ar_valid);
		check_value("r_ready", 0, r_ready);
		check_value("done", 0, done);
		check_value("req_ready", 1, req_ready);
	endtask

	task automatic test_single_beat();
		for (int off = 0; off < 8; off++) begin
			access_counting_beats(make_req(1, 0, SIZE_BYTE, 32'h20 + off,
				word_t'(next_stim())), 32'h20, 1);
			access_counting_beats(make_req(0, 1, SIZE_BYTE, 32'h20 + off, '0), 32'h20, 1);
			if (off < 7) begin
				access_counting_beats(make_req(1, 0, SIZE_HALF, 32'h40 + off,
					word_t'(next_stim())), 32'h40, 1);
				access_counting_beats(make_req(0, 1, SIZE_HALF, 32'h40 + off, '0),
					32'h40, 1);
			end
		end
	endtask

	// words at offsets 5 to 7 and a halfword at 7 cross into the next beat
	task automatic test_split();
		mem_req_t r;
		addr_t base;
		for (int k = 0; k < 4; k++) begin
			base = 32'h80 + 16 * k;
			r = make_req(1, 0, (k < 3) ? SIZE_WORD : SIZE_HALF,
				base + ((k < 3) ? 5 + k : 7), word_t'(next_stim()));
			access_counting_beats(r, base, 2);
			r.is_store = 1'b0;
			access_counting_beats(r, base, 2);
		end
	endtask

	task automatic test_extend();
		word_t result;
		access_and_check(make_req(1, 0, SIZE_HALF, 32'hc2, 32'h1234_f08c));
		run_access(make_req(0, 0, SIZE_BYTE, 32'hc2, '0), result);
		check_value("load_data", 32'hffff_ff8c, result);
		run_access(make_req(0, 1, SIZE_BYTE, 32'hc2, '0), result);
		check_value("load_data", 32'h0000_008c, result);
		run_access(make_req(0, 0, SIZE_HALF, 32'hc2, '0), result);
		check_value("load_data", 32'hffff_f08c, result);
		run_access(make_req(0, 1, SIZE_HALF, 32'hc2, '0), result);
		check_value("load_data", 32'h0000_f08c, result);
		access_and_check(make_req(1, 0, SIZE_BYTE, 32'hcf, 32'h1234_5680));
		run_access(make_req(0, 0, SIZE_BYTE, 32'hcf, '0), result);
		check_value("load_data", 32'hffff_ff80, result);
	endtask

	// each request is presented in the done cycle of the one before
	task automatic test_random_stream();
		int unsigned pick;
		for (int n = 0; n < 40; n++) begin
			pick = next_stim();
			access_and_check(make_req(pick[0], pick[1], size_t'(pick[3:2] % 3),
				addr_t'(next_stim() % 232), word_t'(next_stim())));
		end
	endtask

	initial begin : main
		reset = 1'b1;
		req_valid = 1'b0;
		req = '0;
		for (int i = 0; i < MEM_BYTES; i++) begin
			model[i] = fill_byte(i);
		end
		repeat (5) step();
		reset = 1'b0;
		test_reset_state();
		test_single_beat();
		test_split();
		test_extend();
		test_random_stream();
		if (uut.u_master.u_checker.error_count == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

/* flist.f */
src/lsu_pkg.sv
src/lsu_top.sv
src/lsu_req_decode.sv
src/lsu_store_lane.sv
src/lsu_bus_master.sv
src/lsu_load_align.sv
+incdir+dv
dv/lsu_checker.sv
dv/lsu_tb.sv

/* src/lsu_bus_master.sv */
`timescale 1ns/10ps

module lsu_bus_master (
	input  logic clock,
	input  logic reset,
	input  logic plan_valid,
	input  lsu_pkg::mem_plan_t plan,
	input  lsu_pkg::lane_out_t [lsu_pkg::BEAT_BYTES-1:0] lanes,
	output logic aw_valid,
	input  logic aw_ready,
	output lsu_pkg::addr_t aw_addr,
	output logic w_valid,
	input  logic w_ready,
	output lsu_pkg::beat_t w_data,
	output lsu_pkg::strb_t w_strb,
	input  logic b_valid,
	output logic b_ready,
	output logic ar_valid,
	input  logic ar_ready,
	output lsu_pkg::addr_t ar_addr,
	input  logic r_valid,
	output logic r_ready,
	output logic second_beat,
	output logic r_fire,
	output logic done
);
	import lsu_pkg::*;

	wr_state_t wr_state;
	wr_state_t wr_next;
	rd_state_t rd_state;
	rd_state_t rd_next;
	addr_t beat_addr;
	logic aw_fire;
	logic w_fire;
	logic b_fire;
	logic ar_fire;
	logic more;

	assign aw_fire = aw_valid && aw_ready;
	assign w_fire = w_valid && w_ready;
	assign b_fire = b_valid && b_ready;
	assign ar_fire = ar_valid && ar_ready;
	assign r_fire = r_valid && r_ready;

	// another beat follows the current one
	assign more = plan.need_second && !second_beat;

	always_comb begin
		wr_next = wr_state;
		case (wr_state)
			W_IDLE: if (plan_valid && plan.is_store) wr_next = W_ADDR;
			W_ADDR: if (aw_fire) wr_next = W_DATA;
			W_DATA: if (w_fire) wr_next = W_RESP;
			W_RESP: if (b_fire) wr_next = more ? W_ADDR : W_DONE;
			W_DONE: wr_next = W_IDLE;
			default: wr_next = W_IDLE;
		endcase
	end

	always_comb begin
		rd_next = rd_state;
		case (rd_state)
			R_IDLE: if (plan_valid && !plan.is_store) rd_next = R_ADDR;
			R_ADDR: if (ar_fire) rd_next = R_DATA;
			R_DATA: if (r_fire) rd_next = more ? R_ADDR : R_DONE;
			R_DONE: rd_next = R_IDLE;
			default: rd_next = R_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_state <= W_IDLE;
			rd_state <= R_IDLE;
		end else begin
			wr_state <= wr_next;
			rd_state <= rd_next;
		end
	end

	// set after the first beat of a split access, cleared at the end
	always_ff @(posedge clock) begin
		if (reset) begin
			second_beat <= 1'b0;
		end else if (done) begin
			second_beat <= 1'b0;
		end else if ((b_fire || r_fire) && plan.need_second) begin
			second_beat <= 1'b1;
		end
	end

	assign aw_valid = wr_state == W_ADDR;
	assign w_valid = wr_state == W_DATA;
	assign b_ready = wr_state == W_RESP;
	assign ar_valid = rd_state == R_ADDR;
	assign r_ready = rd_state == R_DATA;
	assign done = (wr_state == W_DONE) || (rd_state == R_DONE);

	assign beat_addr = second_beat ? plan.base + addr_t'(BEAT_BYTES) : plan.base;
	assign aw_addr = beat_addr;
	assign ar_addr = beat_addr;

	// pick each lane's strobe and byte for the beat in flight
	always_comb begin
		for (int j = 0; j < BEAT_BYTES; j++) begin
			w_strb[j] = second_beat ? lanes[j].strb_second : lanes[j].strb_first;
			w_data[8*j +: 8] = second_beat ? lanes[j].byte_second : lanes[j].byte_first;
		end
	end

endmodule

/* src/lsu_load_align.sv */
`timescale 1ns/10ps

module lsu_load_align (
	input  logic clock,
	input  logic reset,
	input  lsu_pkg::mem_plan_t plan,
	input  lsu_pkg::beat_t r_data,
	input  logic r_fire,
	input  logic second_beat,
	output lsu_pkg::word_t load_data
);
	import lsu_pkg::*;

	beat_t beat_lo;
	beat_t beat_hi;
	logic [2*$bits(beat_t)-1:0] window;
	logic [2*$bits(beat_t)-1:0] shifted;
	word_t raw;

	// first beat goes low, the beat at base+8 goes high
	always_ff @(posedge clock) begin
		if (reset) begin
			beat_lo <= '0;
			beat_hi <= '0;
		end else if (r_fire) begin
			if (second_beat) begin
				beat_hi <= r_data;
			end else begin
				beat_lo <= r_data;
			end
		end
	end

	// high half is unused unless the access was split
	assign window = {beat_hi, beat_lo};
	assign shifted = window >> {plan.offset, 3'b000};
	assign raw = shifted[$bits(word_t)-1:0];

	always_comb begin
		case (plan.size)
			SIZE_BYTE: begin
				load_data = {{24{raw[7] & !plan.is_unsigned}}, raw[7:0]};
			end
			SIZE_HALF: begin
				load_data = {{16{raw[15] & !plan.is_unsigned}}, raw[15:0]};
			end
			default: begin
				load_data = raw;
			end
		endcase
	end

endmodule

/* src/lsu_pkg.sv */
package lsu_pkg;

	localparam int unsigned BEAT_BYTES = 8;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [8*BEAT_BYTES-1:0] beat_t;
	typedef logic [BEAT_BYTES-1:0] strb_t;
	typedef logic [7:0] byte_t;
	typedef logic [2:0] offset_t;
	typedef logic [1:0] size_t;

	// access size codes, bytes = 1 << code
	localparam size_t SIZE_BYTE = 2'd0;
	localparam size_t SIZE_HALF = 2'd1;
	localparam size_t SIZE_WORD = 2'd2;

	typedef struct packed {
		logic is_store;
		logic is_unsigned;
		size_t size;
		addr_t addr;
		word_t wdata;
	} mem_req_t;

	// request after decode, base is 8-byte aligned
	typedef struct packed {
		logic is_store;
		logic is_unsigned;
		size_t size;
		addr_t base;
		offset_t offset;
		logic need_second;
		word_t wdata;
	} mem_plan_t;

	typedef struct packed {
		logic strb_first;
		logic strb_second;
		byte_t byte_first;
		byte_t byte_second;
	} lane_out_t;

	typedef enum logic [2:0] {W_IDLE, W_ADDR, W_DATA, W_RESP, W_DONE} wr_state_t;
	typedef enum logic [1:0] {R_IDLE, R_ADDR, R_DATA, R_DONE} rd_state_t;

	function automatic logic [3:0] size_bytes(input size_t size);
		return 4'd1 << size;
	endfunction

endpackage

/* src/lsu_req_decode.sv */
`timescale 1ns/10ps

module lsu_req_decode (
	input  logic clock,
	input  logic reset,
	input  logic req_valid,
	input  lsu_pkg::mem_req_t req,
	input  logic done,
	output logic req_ready,
	output logic plan_valid,
	output lsu_pkg::mem_plan_t plan
);
	import lsu_pkg::*;

	mem_req_t held;
	logic [3:0] span_end;
	logic take;

	// free when idle, or when the current access ends this cycle
	assign req_ready = !plan_valid || done;
	assign take = req_valid && req_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			plan_valid <= 1'b0;
		end else if (take) begin
			plan_valid <= 1'b1;
		end else if (done) begin
			plan_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (take) begin
			held <= req;
		end
	end

	// one past the last byte, relative to the aligned base
	assign span_end = {1'b0, held.addr[2:0]} + size_bytes(held.size);

	assign plan.is_store = held.is_store;
	assign plan.is_unsigned = held.is_unsigned;
	assign plan.size = held.size;
	assign plan.base = {held.addr[31:3], 3'b000};
	assign plan.offset = held.addr[2:0];
	assign plan.need_second = span_end > 4'(BEAT_BYTES);
	assign plan.wdata = held.wdata;

endmodule

/* src/lsu_store_lane.sv */
`timescale 1ns/10ps

module lsu_store_lane #(
	parameter int unsigned lane = 0
) (
	input  lsu_pkg::mem_plan_t plan,
	output lsu_pkg::lane_out_t lane_out
);
	import lsu_pkg::*;

	logic [3:0] first_pos;
	logic [3:0] second_pos;
	logic [3:0] start;
	logic [3:0] stop;
	logic [3:0] first_rel;
	logic [3:0] second_rel;
	logic hit_first;
	logic hit_second;

	// this lane covers window bytes lane and lane+8
	assign first_pos = 4'(lane);
	assign second_pos = 4'(lane + BEAT_BYTES);
	assign start = {1'b0, plan.offset};
	assign stop = start + size_bytes(plan.size);
	assign first_rel = first_pos - start;
	assign second_rel = second_pos - start;

	assign hit_first = (first_pos >= start) && (first_pos < stop);
	assign hit_second = second_pos < stop;

	assign lane_out.strb_first = hit_first;
	assign lane_out.strb_second = hit_second;
	assign lane_out.byte_first = hit_first ? plan.wdata[{first_rel[1:0], 3'b000} +: 8] : '0;
	assign lane_out.byte_second = hit_second ? plan.wdata[{second_rel[1:0], 3'b000} +: 8] : '0;

endmodule

/* src/lsu_top.sv */
`timescale 1ns/10ps

module lsu_top (
	input  logic clock,
	input  logic reset,
	input  logic req_valid,
	input  lsu_pkg::mem_req_t req,
	output logic req_ready,
	output logic done,
	output lsu_pkg::word_t load_data,
	output logic aw_valid,
	input  logic aw_ready,
	output lsu_pkg::addr_t aw_addr,
	output logic w_valid,
	input  logic w_ready,
	output lsu_pkg::beat_t w_data,
	output lsu_pkg::strb_t w_strb,
	input  logic b_valid,
	output logic b_ready,
	output logic ar_valid,
	input  logic ar_ready,
	output lsu_pkg::addr_t ar_addr,
	input  logic r_valid,
	output logic r_ready,
	input  lsu_pkg::beat_t r_data
);
	import lsu_pkg::*;

	logic plan_valid;
	mem_plan_t plan;
	lane_out_t [BEAT_BYTES-1:0] lanes;
	logic second_beat;
	logic r_fire;

	lsu_req_decode u_decode (
		.clock(clock),
		.reset(reset),
		.req_valid(req_valid),
		.req(req),
		.done(done),
		.req_ready(req_ready),
		.plan_valid(plan_valid),
		.plan(plan)
	);

	// one store lane per byte of the beat
	for (genvar j = 0; j < BEAT_BYTES; j++) begin : g_lane
		lsu_store_lane #(
			.lane(j)
		) u_lane (
			.plan(plan),
			.lane_out(lanes[j])
		);
	end

	lsu_bus_master u_master (
		.clock(clock),
		.reset(reset),
		.plan_valid(plan_valid),
		.plan(plan),
		.lanes(lanes),
		.aw_valid(aw_valid),
		.aw_ready(aw_ready),
		.aw_addr(aw_addr),
		.w_valid(w_valid),
		.w_ready(w_ready),
		.w_data(w_data),
		.w_strb(w_strb),
		.b_valid(b_valid),
		.b_ready(b_ready),
		.ar_valid(ar_valid),
		.ar_ready(ar_ready),
		.ar_addr(ar_addr),
		.r_valid(r_valid),
		.r_ready(r_ready),
		.second_beat(second_beat),
		.r_fire(r_fire),
		.done(done)
	);

	lsu_load_align u_align (
		.clock(clock),
		.reset(reset),
		.plan(plan),
		.r_data(r_data),
		.r_fire(r_fire),
		.second_beat(second_beat),
		.load_data(load_data)
	);

endmodule
